//--- br_isa_pkg.sv
package br_isa_pkg;

    localparam int XLEN   = 32;
    localparam int COND_W = 4;

    typedef logic [XLEN-1:0] word_t; // data or address word

    // branch condition codes, encodings follow the decoder
    typedef enum logic [COND_W-1:0] {
        JIRL = 4'b0011,
        B    = 4'b0100,
        BL   = 4'b0101,
        BEQ  = 4'b0110,
        BNE  = 4'b0111,
        BLT  = 4'b1000,
        BGE  = 4'b1001,
        BLTU = 4'b1010,
        BGEU = 4'b1011
    } br_cond_t;

    typedef struct packed {
        logic     is_branch;
        br_cond_t cond;
    } br_uop_t;

endpackage

//--- br_pipe_pkg.sv
package br_pipe_pkg;

    localparam int QDEPTH       = 4; // also the sender's initial credits
    localparam int QPTR_W       = $clog2(QDEPTH);
    localparam int FLUSH_CYCLES = 3;
    localparam int FLUSH_CNT_W  = $clog2(FLUSH_CYCLES);
    localparam int CREDIT_W     = 3;

    typedef logic [CREDIT_W-1:0] credit_t; // credits returned per cycle

    typedef struct packed {
        br_isa_pkg::word_t   pc;
        br_isa_pkg::word_t   imm;         // word offset
        br_isa_pkg::word_t   sr1;
        br_isa_pkg::word_t   sr2;
        br_isa_pkg::word_t   pred_target;
        br_isa_pkg::br_uop_t uop;
        logic                slot;        // issue way
        logic                solo;        // paired slot not issued
        logic                pred_taken;
    } br_issue_t;

    typedef struct packed {
        br_isa_pkg::word_t pc;
        br_isa_pkg::word_t target;
        logic              taken;
        logic              dir_fail;
        logic              addr_fail;
    } br_result_t;

    typedef struct packed {
        br_isa_pkg::word_t next_pc;
    } br_redirect_t;

    typedef enum logic {
        RUN,
        FLUSH
    } redir_state_t;

endpackage

//--- br_resolve.sv
`timescale 1ns/10ps

module br_resolve (
    input  br_pipe_pkg::br_issue_t  pkt,
    output br_pipe_pkg::br_result_t res
);
    import br_isa_pkg::*;
    import br_pipe_pkg::*;

    word_t offset;
    word_t fall_through;
    word_t real_target;
    logic  sr1_eq_sr2;
    logic  sr1_lt_sr2_u;
    logic  sr1_lt_sr2_s;
    logic  cond_met;
    logic  taken;
    logic  dir_fail;
    logic  addr_fail;

    assign offset = {pkt.imm[XLEN-3:0], 2'b00};

    // next sequential fetch, pair of slots unless solo or upper way
    assign fall_through = (!pkt.slot && !pkt.solo) ? pkt.pc + word_t'(8) :
                                                     pkt.pc + word_t'(4);

    assign real_target = (pkt.uop.cond == JIRL) ? pkt.sr1 + offset : // register relative
                                                  pkt.pc + offset;

    assign sr1_eq_sr2   = (pkt.sr1 == pkt.sr2);
    assign sr1_lt_sr2_u = (pkt.sr1 < pkt.sr2);
    assign sr1_lt_sr2_s = (pkt.sr1[XLEN-1] && !pkt.sr2[XLEN-1]) ? 1'b1 :
                          (!pkt.sr1[XLEN-1] && pkt.sr2[XLEN-1]) ? 1'b0 :
                          sr1_lt_sr2_u; // same sign, unsigned order holds

    always_comb begin
        case (pkt.uop.cond)
            JIRL, B, BL: cond_met = 1'b1;
            BEQ:         cond_met = sr1_eq_sr2;
            BNE:         cond_met = !sr1_eq_sr2;
            BLT:         cond_met = sr1_lt_sr2_s;
            BGE:         cond_met = !sr1_lt_sr2_s;
            BLTU:        cond_met = sr1_lt_sr2_u;
            BGEU:        cond_met = !sr1_lt_sr2_u;
            default:     cond_met = 1'b0;
        endcase
    end

    assign taken = pkt.uop.is_branch && cond_met;

    always_comb begin
        dir_fail  = 1'b0;
        addr_fail = 1'b0;
        if (taken != pkt.pred_taken) begin // wrong direction
            dir_fail  = 1'b1;
            addr_fail = 1'b1;
        end else if (taken && pkt.pred_taken && (pkt.pred_target != real_target)) begin
            addr_fail = 1'b1; // right direction, wrong place
        end
    end

    assign res.pc        = pkt.pc;
    assign res.target    = taken ? real_target : fall_through;
    assign res.taken     = taken;
    assign res.dir_fail  = dir_fail;
    assign res.addr_fail = addr_fail;

endmodule

//--- br_queue.sv
`timescale 1ns/10ps

module br_queue (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  br_pipe_pkg::br_issue_t push_data,
    input  logic                   pop,
    input  logic                   clear,
    input  logic                   drop,
    output br_pipe_pkg::br_issue_t head,
    output logic                   head_valid,
    output br_pipe_pkg::credit_t   credit_return
);
    import br_pipe_pkg::*;

    br_issue_t         mem [QDEPTH];
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W:0]   count;
    logic              accept;

    assign accept     = push && !drop && !clear;
    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr        <= '0;
            wr_ptr        <= '0;
            count         <= '0;
            credit_return <= '0;
        end else if (clear) begin
            rd_ptr        <= '0;
            wr_ptr        <= '0;
            count         <= '0;
            credit_return <= credit_t'(count) + credit_t'(push); // whole queue plus arrival
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count         <= count + (QPTR_W+1)'(accept) - (QPTR_W+1)'(pop);
            credit_return <= credit_t'(pop) + credit_t'(push && drop);
        end
    end

    // sender must hold a credit for every push
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (push && count == (QPTR_W+1)'(QDEPTH)) |-> clear);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (count != '0));

endmodule

//--- br_flush_timer.sv
`timescale 1ns/10ps

module br_flush_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);
    import br_pipe_pkg::*;

    logic [FLUSH_CNT_W-1:0] cnt;
    logic                   busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            busy <= 1'b0;
        end else if (start) begin
            cnt  <= FLUSH_CNT_W'(FLUSH_CYCLES - 1);
            busy <= 1'b1;
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign done = busy && (cnt == '0); // last cycle of the window

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy);

endmodule

//--- br_redirect_fsm.sv
`timescale 1ns/10ps

module br_redirect_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     head_valid,
    input  br_pipe_pkg::br_result_t  head_res,
    input  logic                     timer_done,
    output logic                     pop,
    output logic                     clear,
    output logic                     drop,
    output logic                     timer_start,
    output logic                     result_valid,
    output br_pipe_pkg::br_result_t  result,
    output logic                     redirect_valid,
    output br_pipe_pkg::br_redirect_t redirect
);
    import br_pipe_pkg::*;

    redir_state_t state;
    logic         mispredict;

    assign pop         = (state == RUN) && head_valid;
    assign mispredict  = pop && head_res.addr_fail; // decided before the result register
    assign clear       = mispredict;
    assign timer_start = mispredict;
    assign drop        = (state == FLUSH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= RUN;
            result_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            result_valid   <= pop;
            redirect_valid <= mispredict;
            case (state)
                RUN: begin
                    if (mispredict) begin
                        state <= FLUSH;
                    end
                end
                FLUSH: begin
                    if (timer_done) begin
                        state <= RUN;
                    end
                end
                default: state <= RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result <= head_res;
        end
        if (mispredict) begin
            redirect.next_pc <= head_res.target;
        end
    end

    // queue was cleared on entry and drops every arrival
    a_flush_queue_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (state == FLUSH) |-> !head_valid);

endmodule

//--- br_exec_top.sv
`timescale 1ns/10ps

module br_exec_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      issue_valid,
    input  br_pipe_pkg::br_issue_t    issue,
    output br_pipe_pkg::credit_t      credit_return,
    output logic                      result_valid,
    output br_pipe_pkg::br_result_t   result,
    output logic                      redirect_valid,
    output br_pipe_pkg::br_redirect_t redirect
);
    import br_pipe_pkg::*;

    br_issue_t  head;
    br_result_t head_res;
    logic       head_valid;
    logic       pop;
    logic       clear;
    logic       drop;
    logic       timer_start;
    logic       timer_done;

    br_queue i_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (issue_valid),
        .push_data     (issue),
        .pop           (pop),
        .clear         (clear),
        .drop          (drop),
        .head          (head),
        .head_valid    (head_valid),
        .credit_return (credit_return)
    );

    br_resolve i_resolve (
        .pkt (head),
        .res (head_res)
    );

    br_flush_timer i_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .done  (timer_done)
    );

    br_redirect_fsm i_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .head_valid     (head_valid),
        .head_res       (head_res),
        .timer_done     (timer_done),
        .pop            (pop),
        .clear          (clear),
        .drop           (drop),
        .timer_start    (timer_start),
        .result_valid   (result_valid),
        .result         (result),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

endmodule

//--- tb_br_exec.sv
`timescale 1ns/10ps

module tb_br_exec;
    import br_isa_pkg::*;
    import br_pipe_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 5;
    localparam int RANDOM_PKTS = 200;

    logic         clk;
    logic         rst_n;
    logic         issue_valid;
    br_issue_t    issue;
    credit_t      credit_return;
    logic         result_valid;
    br_result_t   result;
    logic         redirect_valid;
    br_redirect_t redirect;

    br_issue_t stim_q [$];
    string     stim_name_q [$];
    br_issue_t exp_q [$];       // issued, not yet resolved
    string     exp_name_q [$];

    int seed             = 21;
    int stim_idx         = 0;
    int credits          = QDEPTH; // sender side credit counter
    int drop_left        = 0;
    int issued_total     = 0;
    int returned_total   = 0;
    int mispred_cnt      = 0;
    int cycle            = 0;
    int last_redir_cycle = -1000;
    int result_errors    = 0;
    int redirect_errors  = 0;
    int credit_errors    = 0;
    int other_errors     = 0;
    bit refill           = 1'b0;
    bit stim_built       = 1'b0;

    br_exec_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .credit_return  (credit_return),
        .result_valid   (result_valid),
        .result         (result),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic br_result_t ref_resolve(input br_issue_t p);
        br_result_t r;
        word_t      fall;
        word_t      tgt;
        logic       cond;
        fall = (p.slot == 1'b0 && p.solo == 1'b0) ? p.pc + 32'd8 : p.pc + 32'd4;
        case (p.uop.cond)
            JIRL, B, BL: cond = 1'b1;
            BEQ:         cond = (p.sr1 == p.sr2);
            BNE:         cond = (p.sr1 != p.sr2);
            BLT:         cond = ($signed(p.sr1) < $signed(p.sr2));
            BGE:         cond = ($signed(p.sr1) >= $signed(p.sr2));
            BLTU:        cond = (p.sr1 < p.sr2);
            BGEU:        cond = (p.sr1 >= p.sr2);
            default:     cond = 1'b0;
        endcase
        tgt = ((p.uop.cond == JIRL) ? p.sr1 : p.pc) + (p.imm << 2);
        r.pc        = p.pc;
        r.taken     = p.uop.is_branch && cond;
        r.target    = r.taken ? tgt : fall;
        r.dir_fail  = (r.taken != p.pred_taken);
        r.addr_fail = r.dir_fail || (r.taken && p.pred_taken && p.pred_target != tgt);
        return r;
    endfunction

    function automatic br_issue_t random_pkt(input br_cond_t cond);
        br_issue_t p;
        int        r;
        r               = $random(seed);
        p.pc            = word_t'($random(seed)) & 32'hffff_fffc;
        p.imm           = {{22{r[9]}}, r[9:0]}; // small signed word offset
        p.sr1           = $random(seed);
        p.sr2           = $random(seed);
        p.pred_target   = $random(seed);
        p.uop.is_branch = 1'b1;
        p.uop.cond      = cond;
        p.slot          = r[10];
        p.solo          = r[11];
        p.pred_taken    = 1'b0;
        return p;
    endfunction

    function automatic br_issue_t predict_right(input br_issue_t p);
        br_issue_t  q;
        br_result_t r;
        q             = p;
        r             = ref_resolve(q);
        q.pred_taken  = r.taken;
        q.pred_target = r.target;
        return q;
    endfunction

    task automatic add_pkt(input string name, input br_issue_t p);
        br_result_t r;
        r = ref_resolve(p);
        stim_q.push_back(p);
        stim_name_q.push_back(name);
        if (r.addr_fail) begin
            mispred_cnt++;
        end
    endtask

    task automatic build_stimulus();
        br_cond_t  conds [9];
        string     rel [5];
        word_t     a_tab [5];
        word_t     b_tab [5];
        br_issue_t p;
        int        c;
        int        k;
        int        r;
        conds = '{JIRL, B, BL, BEQ, BNE, BLT, BGE, BLTU, BGEU};
        rel   = '{"eq", "lt", "gt", "neg_pos", "pos_neg"};
        a_tab = '{32'd77, 32'd100, 32'd200, 32'hffff_fff0, 32'd16};
        b_tab = '{32'd77, 32'd200, 32'd100, 32'd16, 32'hffff_fff0};
        for (c = 3; c < 9; c++) begin
            for (k = 0; k < 5; k++) begin
                p     = random_pkt(conds[c]);
                p.sr1 = a_tab[k];
                p.sr2 = b_tab[k];
                add_pkt($sformatf("%s_%s", conds[c].name(), rel[k]), predict_right(p));
            end
        end
        for (c = 0; c < 3; c++) begin
            add_pkt($sformatf("%s_jump", conds[c].name()), predict_right(random_pkt(conds[c])));
        end
        for (k = 0; k < 4; k++) begin
            p               = random_pkt(BEQ);
            p.uop.is_branch = 1'b0;
            p.slot          = k[0];
            p.solo          = k[1];
            add_pkt($sformatf("nonbranch_slot%0d_solo%0d", k[0], k[1]), p);
        end
        // each miss is followed by two younger packets that get flushed
        p            = random_pkt(BEQ);
        p.sr2        = p.sr1;
        add_pkt("dir_miss_taken", p);
        add_pkt("younger_a", predict_right(random_pkt(B)));
        add_pkt("younger_b", predict_right(random_pkt(BL)));
        p            = random_pkt(BNE);
        p.sr2        = p.sr1;
        p.pred_taken = 1'b1;
        add_pkt("dir_miss_not_taken", p);
        add_pkt("younger_c", predict_right(random_pkt(B)));
        add_pkt("younger_d", predict_right(random_pkt(BL)));
        p             = predict_right(random_pkt(B));
        p.pred_target = p.pred_target ^ 32'h40;
        add_pkt("addr_miss_b", p);
        add_pkt("younger_e", predict_right(random_pkt(B)));
        add_pkt("younger_f", predict_right(random_pkt(BL)));
        p             = predict_right(random_pkt(JIRL));
        p.pred_target = p.pred_target + 32'd4;
        add_pkt("addr_miss_jirl", p);
        for (k = 0; k < RANDOM_PKTS; k++) begin
            r = $random(seed);
            c = int'(r[7:0]) % 9;
            p = random_pkt(conds[c]);
            if (r[9:8] == 2'b00) begin
                p.sr2 = p.sr1;
            end
            if (r[14:12] == 3'b000) begin
                p.uop.is_branch = 1'b0;
            end
            p = predict_right(p);
            if (r[18:15] == 4'd0) begin
                p.pred_taken = !p.pred_taken; // direction miss
            end else if (r[18:15] == 4'd1) begin
                p.pred_target = p.pred_target + 32'd8;
            end
            add_pkt($sformatf("random_%0d", k), p);
        end
    endtask

    task automatic check_result(input string name, input br_result_t exp, input br_result_t act);
        if (act !== exp) begin
            result_errors++;
            $display("Mismatch %s: expected pc %h target %h taken %b dir %b addr %b",
                     name, exp.pc, exp.target, exp.taken, exp.dir_fail, exp.addr_fail);
            $display("  actual pc %h target %h taken %b dir %b addr %b",
                     act.pc, act.target, act.taken, act.dir_fail, act.addr_fail);
        end
    endtask

    task automatic check_redirect(input string name, input br_redirect_t exp,
                                  input br_redirect_t act);
        if (act !== exp) begin
            redirect_errors++;
            $display("Mismatch %s: expected next_pc %h actual next_pc %h",
                     name, exp.next_pc, act.next_pc);
        end
    endtask

    task automatic check_credit(input string name, input credit_t exp, input credit_t act);
        if (act !== exp) begin
            credit_errors++;
            $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic print_summary();
        $display("errors: result %0d, redirect %0d, credit %0d, other %0d (%0d issued)",
                 result_errors, redirect_errors, credit_errors, other_errors, issued_total);
    endtask

    // credit model and issue driver
    always @(posedge clk) begin : drive_issue
        logic in_flush;
        if (rst_n) begin
            credits        = credits + int'(credit_return);
            returned_total = returned_total + int'(credit_return);
            if (credits < 0 || credits > QDEPTH) begin
                credit_errors++;
                $display("Sender credit counter left its range, now %0d", credits);
            end
            if (redirect_valid) begin
                drop_left = FLUSH_CYCLES - 1; // issues that land in the flush window
                refill    = 1'b1;
            end
            if (refill && credits == QDEPTH) begin
                refill = 1'b0;
            end
            in_flush = (drop_left > 0);
            if (drop_left > 0) begin
                drop_left--;
            end
            if (!refill && credits > 0 && stim_idx < stim_q.size()) begin
                issue_valid <= 1'b1;
                issue       <= stim_q[stim_idx];
                if (!in_flush) begin // a dropped packet is sent again later
                    exp_q.push_back(stim_q[stim_idx]);
                    exp_name_q.push_back(stim_name_q[stim_idx]);
                    stim_idx++;
                end
                credits--;
                issued_total++;
            end else begin
                issue_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : compare_results
        br_issue_t    pkt;
        br_result_t   exp_res;
        br_redirect_t exp_redir;
        string        name;
        if (rst_n) begin
            cycle++;
            if (result_valid) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("Result for pc %h arrived with nothing outstanding", result.pc);
                end else begin
                    pkt     = exp_q.pop_front();
                    name    = exp_name_q.pop_front();
                    exp_res = ref_resolve(pkt);
                    check_result(name, exp_res, result);
                    if (cycle - last_redir_cycle < FLUSH_CYCLES) begin
                        other_errors++;
                        $display("Result %s came %0d cycles after a redirect",
                                 name, cycle - last_redir_cycle);
                    end
                    if (exp_res.addr_fail && !redirect_valid) begin
                        redirect_errors++;
                        $display("No redirect came with mispredicted %s", name);
                    end else if (!exp_res.addr_fail && redirect_valid) begin
                        redirect_errors++;
                        $display("Redirect came with correctly predicted %s", name);
                    end else if (redirect_valid) begin
                        exp_redir.next_pc = exp_res.target;
                        check_redirect(name, exp_redir, redirect);
                    end
                end
                if (redirect_valid) begin
                    exp_q.delete(); // younger packets are flushed
                    exp_name_q.delete();
                    last_redir_cycle = cycle;
                end
            end else if (redirect_valid) begin
                redirect_errors++;
                $display("redirect_valid was high without result_valid");
            end
        end
    end

    initial begin : main
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        build_stimulus();
        stim_built = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_credit("reset_credit_return", '0, credit_return);
        if (result_valid || redirect_valid) begin
            other_errors++;
            $display("result_valid or redirect_valid was high right after reset");
        end
        while (!(stim_idx == stim_q.size() && exp_q.size() == 0 && drop_left == 0
                 && !refill && credits == QDEPTH)) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        check_credit("final_credits", credit_t'(QDEPTH), credit_t'(credits));
        if (returned_total != issued_total) begin
            credit_errors++;
            $display("Mismatch credit_total: expected %0d actual %0d",
                     issued_total, returned_total);
        end
        print_summary();
        if (result_errors + redirect_errors + credit_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (stim_built);
        limit = (stim_q.size() + mispred_cnt * (FLUSH_CYCLES + QDEPTH)) * 4 + RST_CYCLES;
        repeat (limit) @(posedge clk);
        other_errors++;
        $display("Timeout: the run was still busy after %0d cycles", limit);
        print_summary();
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- all.f
br_isa_pkg.sv
br_pipe_pkg.sv
br_resolve.sv
br_queue.sv
br_flush_timer.sv
br_redirect_fsm.sv
br_exec_top.sv
tb_br_exec.sv

//--- Makefile
# Verilator build and run for the branch execution subsystem

VERILATOR ?= verilator
TOP       ?= tb_br_exec
RTL_TOP   ?= br_exec_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
